//--- Makefile
# Verilator build and run of the register-file calculator testbench

VERILATOR ?= verilator
TOP       ?= calcTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= sim passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "result: PASS"; \
	else \
		echo "result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/calcPkg.sv
`include "calc_macros.svh"

package calcPkg;

	// opcode, taken from the first nibble of a command
	typedef enum logic [2:0] {
		opWriteImm       = 3'd0,
		opReadA          = 3'd1,
		opReadAB         = 3'd2,
		opReadAWriteImm  = 3'd3,
		opReadABWriteImm = 3'd4,
		opAdd            = 3'd5,
		opSub            = 3'd6,
		opShl            = 3'd7
	} calcOp;

	// display record layouts
	typedef enum logic [1:0] {
		modeBlank  = 2'd0,
		modeWrite  = 2'd1,
		modeReadA  = 2'd2,
		modeReadAB = 2'd3
	} dispMode;

	// one fully entered command
	typedef struct packed {
		calcOp                   op;
		logic [`CALC_ADDR_W-1:0] rdAddrA;
		logic [`CALC_ADDR_W-1:0] rdAddrB;
		logic [`CALC_ADDR_W-1:0] wrAddr;
		logic [3:0]              shift;
		logic [`CALC_DATA_W-1:0] imm;
	} calcCmd;

	// which registers to show once a command is done
	typedef struct packed {
		dispMode                 mode;
		logic [`CALC_ADDR_W-1:0] addrA;
		logic [`CALC_ADDR_W-1:0] addrB;
	} dispReq;

endpackage

//--- design/calcTop.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module calcTop (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [3:0]              nibble,
	input  logic                    knobA,
	input  logic                    knobB,
	input  logic                    button,
	input  logic                    dispReady,
	output logic                    dispValid,
	output logic [1:0]              dispMode,
	output logic [`CALC_ADDR_W-1:0] dispAddrA,
	output logic [`CALC_ADDR_W-1:0] dispAddrB,
	output logic [`CALC_DATA_W-1:0] dispDataA,
	output logic [`CALC_DATA_W-1:0] dispDataB
);

	import calcPkg::*;

	// entry to executor
	calcCmd cmd;
	logic   cmdValid;
	logic   cmdReady;

	// executor to fetcher
	dispReq req;
	logic   reqValid;
	logic   reqReady;

	// arbiter to RAM
	logic                    ramWe;
	logic [`CALC_ADDR_W-1:0] ramAddr;
	logic [`CALC_DATA_W-1:0] ramWdata;
	logic [`CALC_DATA_W-1:0] ramRdata;

	regBusIf execBus ();
	regBusIf dispBus ();

	knobEntry entry (
		.clk      (clk),
		.rst      (rst),
		.nibble   (nibble),
		.knobA    (knobA),
		.knobB    (knobB),
		.button   (button),
		.cmdValid (cmdValid),
		.cmdReady (cmdReady),
		.cmd      (cmd)
	);

	opExecutor exec (
		.clk      (clk),
		.rst      (rst),
		.cmdValid (cmdValid),
		.cmdReady (cmdReady),
		.cmd      (cmd),
		.bus      (execBus.client),
		.reqValid (reqValid),
		.reqReady (reqReady),
		.req      (req)
	);

	displayFetcher fetch (
		.clk       (clk),
		.rst       (rst),
		.reqValid  (reqValid),
		.reqReady  (reqReady),
		.req       (req),
		.bus       (dispBus.client),
		.dispValid (dispValid),
		.dispReady (dispReady),
		.dispMode  (dispMode),
		.dispAddrA (dispAddrA),
		.dispAddrB (dispAddrB),
		.dispDataA (dispDataA),
		.dispDataB (dispDataB)
	);

	regBusArbiter arb (
		.clk     (clk),
		.rst     (rst),
		.execBus (execBus.arbiter),
		.dispBus (dispBus.arbiter),
		.we      (ramWe),
		.addr    (ramAddr),
		.wdata   (ramWdata),
		.rdata   (ramRdata)
	);

	regFile regs (
		.clk   (clk),
		.rst   (rst),
		.we    (ramWe),
		.addr  (ramAddr),
		.wdata (ramWdata),
		.rdata (ramRdata)
	);

endmodule

//--- design/calc_macros.svh
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// width of one register word
`define CALC_DATA_W 16

// register address width
// low nibble plus one high bit from the knob
`define CALC_ADDR_W 5

// depth of the register file
`define CALC_REGS 32

`endif

//--- design/displayFetcher.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module displayFetcher (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    reqValid,
	output logic                    reqReady,
	input  calcPkg::dispReq         req,
	regBusIf.client                 bus,
	output logic                    dispValid,
	input  logic                    dispReady,
	output calcPkg::dispMode        dispMode,
	output logic [`CALC_ADDR_W-1:0] dispAddrA,
	output logic [`CALC_ADDR_W-1:0] dispAddrB,
	output logic [`CALC_DATA_W-1:0] dispDataA,
	output logic [`CALC_DATA_W-1:0] dispDataB
);

	import calcPkg::*;

	typedef enum logic [2:0] {
		fIdle,
		fReadA,
		fWaitA,
		fReadB,
		fWaitB,
		fHold
	} fetchState;

	fetchState state;

	//////////////////////////////
	// fetch FSM
	//////////////////////////////

	// B read follows A right after its grant, nothing slips between
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fIdle;
		end else begin
			case (state)
				fIdle: begin
					if (reqValid) begin
						state <= fReadA;
					end
				end
				fReadA: begin
					if (bus.gnt) begin
						state <= (dispMode == modeReadAB) ? fReadB : fWaitA;
					end
				end
				fWaitA: begin
					if (bus.rvalid) begin
						state <= fHold;
					end
				end
				fReadB: begin
					if (bus.gnt) begin
						state <= fWaitB;
					end
				end
				fWaitB: begin
					if (bus.rvalid) begin
						state <= fHold;
					end
				end
				fHold: begin
					if (dispReady) begin
						state <= fIdle;
					end
				end
				default: state <= fIdle;
			endcase
		end
	end

	// display record
	// A data lands in fWaitA or the first fReadB cycle
	always_ff @(posedge clk) begin
		if (state == fIdle && reqValid) begin
			dispMode  <= req.mode;
			dispAddrA <= req.addrA;
			dispAddrB <= (req.mode == modeReadAB) ? req.addrB : '0;
			dispDataB <= '0;
		end
		if (bus.rvalid) begin
			if (state == fWaitB) begin
				dispDataB <= bus.rdata;
			end else begin
				dispDataA <= bus.rdata;
			end
		end
	end

	assign reqReady  = (state == fIdle);
	assign dispValid = (state == fHold);

	// reads only
	assign bus.req   = (state == fReadA) || (state == fReadB);
	assign bus.we    = 1'b0;
	assign bus.addr  = (state == fReadB) ? dispAddrB : dispAddrA;
	assign bus.wdata = '0;

	// record frozen while the sink stalls
	assert property (@(posedge clk) disable iff (rst)
		dispValid && !dispReady |=> dispValid
			&& $stable({dispMode, dispAddrA, dispAddrB, dispDataA, dispDataB}));

endmodule

//--- design/knobEntry.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module knobEntry (
	input  logic           clk,
	input  logic           rst,
	input  logic [3:0]     nibble,
	input  logic           knobA,
	input  logic           knobB,
	input  logic           button,
	output logic           cmdValid,
	input  logic           cmdReady,
	output calcPkg::calcCmd cmd
);

	import calcPkg::*;

	// position that no nibble index can reach, even plus three
	localparam logic [4:0] NONE = 5'd24;

	logic [1:0] syncA;
	logic [1:0] syncB;
	logic       armed;
	logic       detent;
	logic [4:0] cnt;
	logic [4:0] idx;
	logic [4:0] total;
	logic [4:0] posA;
	logic [4:0] posB;
	logic [4:0] posSh;
	logic [4:0] posW;
	logic [4:0] posI;

	// nibbles after the opcode, per opcode
	function automatic logic [4:0] fieldCount(calcOp op);
		case (op)
			opWriteImm:       return 5'd6;
			opReadA:          return 5'd2;
			opReadAB:         return 5'd4;
			opReadAWriteImm:  return 5'd8;
			opReadABWriteImm: return 5'd10;
			opShl:            return 5'd5;
			default:          return 5'd6;
		endcase
	endfunction

	//////////////////////////////
	// knob sync and detent
	//////////////////////////////

	// two flops per phase, then rearm on both low
	always_ff @(posedge clk) begin
		if (rst) begin
			syncA <= '0;
			syncB <= '0;
			armed <= 1'b0;
		end else begin
			syncA <= {syncA[0], knobA};
			syncB <= {syncB[0], knobB};
			if (!syncA[1] && !syncB[1]) begin
				armed <= 1'b1;
			end else if (detent) begin
				armed <= 1'b0;
			end
		end
	end

	// both phases high after a low pair
	assign detent = armed && syncA[1] && syncB[1];

	//////////////////////////////
	// field steering
	//////////////////////////////

	// cnt 0 waits for the opcode, cnt n takes field nibble n-1
	assign idx   = cnt - 5'd1;
	assign total = fieldCount(cmd.op);

	// start of each field in the nibble stream
	always_comb begin
		posA  = NONE;
		posB  = NONE;
		posSh = NONE;
		posW  = NONE;
		posI  = NONE;
		case (cmd.op)
			opWriteImm: begin
				posW = 5'd0;
				posI = 5'd2;
			end
			opReadA: begin
				posA = 5'd0;
			end
			opReadAB: begin
				posA = 5'd0;
				posB = 5'd2;
			end
			opReadAWriteImm: begin
				posA = 5'd0;
				posW = 5'd2;
				posI = 5'd4;
			end
			opReadABWriteImm: begin
				posA = 5'd0;
				posB = 5'd2;
				posW = 5'd4;
				posI = 5'd6;
			end
			opShl: begin
				posA  = 5'd0;
				posSh = 5'd2;
				posW  = 5'd3;
			end
			// add and subtract
			default: begin
				posA = 5'd0;
				posB = 5'd2;
				posW = 5'd4;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt      <= '0;
			cmdValid <= 1'b0;
			cmd      <= '0;
		end else if (cmdValid) begin
			// hold until the executor takes it, turns are lost
			if (cmdReady) begin
				cmdValid <= 1'b0;
			end
		end else if (button) begin
			// abandon the partial entry
			cnt <= '0;
			cmd <= '0;
		end else if (detent) begin
			if (cnt == 5'd0) begin
				cmd    <= '0;
				cmd.op <= calcOp'(nibble[2:0]);
				cnt    <= 5'd1;
			end else begin
				// addresses: low nibble, then bit 0 as the high bit
				if (idx == posA) begin
					cmd.rdAddrA[3:0] <= nibble;
				end
				if (idx == posA + 5'd1) begin
					cmd.rdAddrA[`CALC_ADDR_W-1] <= nibble[0];
				end
				if (idx == posB) begin
					cmd.rdAddrB[3:0] <= nibble;
				end
				if (idx == posB + 5'd1) begin
					cmd.rdAddrB[`CALC_ADDR_W-1] <= nibble[0];
				end
				if (idx == posW) begin
					cmd.wrAddr[3:0] <= nibble;
				end
				if (idx == posW + 5'd1) begin
					cmd.wrAddr[`CALC_ADDR_W-1] <= nibble[0];
				end
				if (idx == posSh) begin
					cmd.shift <= nibble;
				end
				// immediate, least significant nibble first
				if (idx == posI) begin
					cmd.imm[3:0] <= nibble;
				end
				if (idx == posI + 5'd1) begin
					cmd.imm[7:4] <= nibble;
				end
				if (idx == posI + 5'd2) begin
					cmd.imm[11:8] <= nibble;
				end
				if (idx == posI + 5'd3) begin
					cmd.imm[15:12] <= nibble;
				end
				if (idx == total - 5'd1) begin
					cnt      <= '0;
					cmdValid <= 1'b1;
				end else begin
					cnt <= cnt + 5'd1;
				end
			end
		end
	end

	// command steady until the executor accepts it
	assert property (@(posedge clk) disable iff (rst)
		cmdValid && !cmdReady |=> cmdValid && $stable(cmd));

	// counter stays within the opcode's fields
	assert property (@(posedge clk) disable iff (rst)
		cnt <= total);

endmodule

//--- design/opExecutor.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module opExecutor (
	input  logic            clk,
	input  logic            rst,
	input  logic            cmdValid,
	output logic            cmdReady,
	input  calcPkg::calcCmd cmd,
	regBusIf.client         bus,
	output logic            reqValid,
	input  logic            reqReady,
	output calcPkg::dispReq req
);

	import calcPkg::*;

	typedef enum logic [2:0] {
		sIdle,
		sReadA,
		sWaitA,
		sReadB,
		sWaitB,
		sWrite,
		sRequest
	} execState;

	execState                state;
	calcCmd                  cmdR;
	logic [`CALC_DATA_W-1:0] opA;
	logic [`CALC_DATA_W-1:0] opB;
	logic [`CALC_DATA_W-1:0] result;

	// alu wraps modulo 2^16
	always_comb begin
		case (cmdR.op)
			opAdd:   result = opA + opB;
			opSub:   result = opA - opB;
			opShl:   result = opA << cmdR.shift;
			default: result = cmdR.imm;
		endcase
	end

	//////////////////////////////
	// command FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sIdle;
		end else begin
			case (state)
				sIdle: begin
					if (cmdValid) begin
						case (cmd.op)
							opAdd, opSub, opShl: state <= sReadA;
							// nothing to do but show
							opReadA, opReadAB:   state <= sRequest;
							default:             state <= sWrite;
						endcase
					end
				end
				sReadA: begin
					if (bus.gnt) begin
						state <= sWaitA;
					end
				end
				sWaitA: begin
					if (bus.rvalid) begin
						state <= (cmdR.op == opShl) ? sWrite : sReadB;
					end
				end
				sReadB: begin
					if (bus.gnt) begin
						state <= sWaitB;
					end
				end
				sWaitB: begin
					if (bus.rvalid) begin
						state <= sWrite;
					end
				end
				sWrite: begin
					if (bus.gnt) begin
						state <= sRequest;
					end
				end
				sRequest: begin
					if (reqReady) begin
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// latched command and operands
	always_ff @(posedge clk) begin
		if (state == sIdle && cmdValid) begin
			cmdR <= cmd;
		end
		if (state == sWaitA && bus.rvalid) begin
			opA <= bus.rdata;
		end
		if (state == sWaitB && bus.rvalid) begin
			opB <= bus.rdata;
		end
	end

	assign cmdReady = (state == sIdle);
	assign reqValid = (state == sRequest);

	// bus side
	assign bus.req   = (state == sReadA) || (state == sReadB) || (state == sWrite);
	assign bus.we    = (state == sWrite);
	assign bus.wdata = result;

	always_comb begin
		case (state)
			sReadB:  bus.addr = cmdR.rdAddrB;
			sWrite:  bus.addr = cmdR.wrAddr;
			default: bus.addr = cmdR.rdAddrA;
		endcase
	end

	// display request from the opcode
	always_comb begin
		req.addrA = cmdR.rdAddrA;
		req.addrB = '0;
		case (cmdR.op)
			opReadA, opReadAWriteImm: begin
				req.mode = modeReadA;
			end
			opReadAB, opReadABWriteImm: begin
				req.mode  = modeReadAB;
				req.addrB = cmdR.rdAddrB;
			end
			default: begin
				req.mode  = modeWrite;
				req.addrA = cmdR.wrAddr;
			end
		endcase
	end

	// no register access while the display request waits
	assert property (@(posedge clk) disable iff (rst)
		reqValid |-> !bus.req);

endmodule

//--- design/regBusArbiter.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module regBusArbiter (
	input  logic                    clk,
	input  logic                    rst,
	regBusIf.arbiter                execBus,
	regBusIf.arbiter                dispBus,
	output logic                    we,
	output logic [`CALC_ADDR_W-1:0] addr,
	output logic [`CALC_DATA_W-1:0] wdata,
	input  logic [`CALC_DATA_W-1:0] rdata
);

	logic rdPending;
	logic rdOwnerDisp;

	// fixed priority, display fetcher first
	assign dispBus.gnt = dispBus.req;
	assign execBus.gnt = execBus.req && !dispBus.req;

	// forward the granted access to the RAM
	always_comb begin
		if (dispBus.req) begin
			we    = dispBus.we;
			addr  = dispBus.addr;
			wdata = dispBus.wdata;
		end else if (execBus.req) begin
			we    = execBus.we;
			addr  = execBus.addr;
			wdata = execBus.wdata;
		end else begin
			we    = 1'b0;
			addr  = execBus.addr;
			wdata = execBus.wdata;
		end
	end

	// owner of the read in flight
	always_ff @(posedge clk) begin
		if (rst) begin
			rdPending   <= 1'b0;
			rdOwnerDisp <= 1'b0;
		end else begin
			rdPending   <= (dispBus.gnt && !dispBus.we) || (execBus.gnt && !execBus.we);
			rdOwnerDisp <= dispBus.gnt;
		end
	end

	// return path, data shared, valid only to the owner
	assign dispBus.rvalid = rdPending && rdOwnerDisp;
	assign execBus.rvalid = rdPending && !rdOwnerDisp;
	assign dispBus.rdata  = rdata;
	assign execBus.rdata  = rdata;

	assert property (@(posedge clk) disable iff (rst)
		!(dispBus.gnt && execBus.gnt));

endmodule

//--- design/regBusIf.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

interface regBusIf;

	// access request from a client
	logic                    req;
	logic                    we;
	logic [`CALC_ADDR_W-1:0] addr;
	logic [`CALC_DATA_W-1:0] wdata;

	// grant and read return from the arbiter
	logic                    gnt;
	logic [`CALC_DATA_W-1:0] rdata;
	logic                    rvalid;

	modport client (
		output req, we, addr, wdata,
		input  gnt, rdata, rvalid
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rdata, rvalid
	);

endinterface

//--- design/regFile.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module regFile (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    we,
	input  logic [`CALC_ADDR_W-1:0] addr,
	input  logic [`CALC_DATA_W-1:0] wdata,
	output logic [`CALC_DATA_W-1:0] rdata
);

	logic [`CALC_DATA_W-1:0] regs [`CALC_REGS];

	// one access per cycle, all registers zero after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CALC_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[addr] <= wdata;
		end
	end

	// read data one cycle after the access
	always_ff @(posedge clk) begin
		rdata <= regs[addr];
	end

endmodule

//--- filelist.f
+incdir+design
+incdir+testbench
design/calcPkg.sv
design/regBusIf.sv
design/knobEntry.sv
design/opExecutor.sv
design/regBusArbiter.sv
design/regFile.sv
design/displayFetcher.sv
design/calcTop.sv
testbench/calcTb.sv

//--- testbench/calcModel.svh
`ifndef CALC_MODEL_SVH
`define CALC_MODEL_SVH

// one display record as seen on the top-level outputs
typedef struct packed {
	logic [1:0]              mode;
	logic [`CALC_ADDR_W-1:0] addrA;
	logic [`CALC_ADDR_W-1:0] addrB;
	logic [`CALC_DATA_W-1:0] dataA;
	logic [`CALC_DATA_W-1:0] dataB;
} recordT;

// model of the register file, cleared like the DUT after reset
logic [`CALC_REGS-1:0][`CALC_DATA_W-1:0] modelRegs = '0;

// LCG state
logic [31:0] lcgState = 32'h1b50a4e5;

function automatic logic [31:0] nextRand();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState;
endfunction

//////////////////////////////
// reference for one command
//////////////////////////////

// applies the command to regs, returns what the display must show
function automatic recordT calcExpected(
	input logic [2:0]                              op,
	input logic [`CALC_ADDR_W-1:0]                 rdA,
	input logic [`CALC_ADDR_W-1:0]                 rdB,
	input logic [`CALC_ADDR_W-1:0]                 wr,
	input logic [3:0]                              sh,
	input logic [`CALC_DATA_W-1:0]                 imm,
	inout logic [`CALC_REGS-1:0][`CALC_DATA_W-1:0] regs
);
	recordT rec;
	rec = '0;
	// write first, so reads show the new value
	case (op)
		3'd0, 3'd3, 3'd4: regs[wr] = imm;
		3'd5: regs[wr] = regs[rdA] + regs[rdB];
		3'd6: regs[wr] = regs[rdA] - regs[rdB];
		// 16 bit context drops the shifted-out bits
		3'd7: regs[wr] = regs[rdA] << sh;
		default: ;
	endcase
	if (op == 3'd1 || op == 3'd3) begin
		rec.mode  = 2'd2;
		rec.addrA = rdA;
		rec.dataA = regs[rdA];
	end else if (op == 3'd2 || op == 3'd4) begin
		rec.mode  = 2'd3;
		rec.addrA = rdA;
		rec.addrB = rdB;
		rec.dataA = regs[rdA];
		rec.dataB = regs[rdB];
	end else begin
		// plain write and the ALU ops show the destination
		rec.mode  = 2'd1;
		rec.addrA = wr;
		rec.dataA = regs[wr];
	end
	return rec;
endfunction

function automatic string recordText(input recordT rec);
	return $sformatf("mode %0d A r%0d=%h B r%0d=%h",
		rec.mode, rec.addrA, rec.dataA, rec.addrB, rec.dataB);
endfunction

`endif

//--- testbench/calcTb.sv
`timescale 1ns/10ps
`include "calc_macros.svh"

module calcTb;

	`include "calcModel.svh"

	// detent length as driven by turnKnob
	localparam int detentCycles  = 12;
	// rough totals over all tests below
	localparam int totalDetents  = 300;
	localparam int totalCommands = 48;
	localparam int settleCycles  = 40;
	localparam int stallCycles   = 100;
	localparam int watchdogCycles =
		2 * (totalDetents * detentCycles + totalCommands * settleCycles + stallCycles);

	logic                    clk;
	logic                    rst;
	logic [3:0]              nibble;
	logic                    knobA;
	logic                    knobB;
	logic                    button;
	logic                    dispReady;
	logic                    dispValid;
	logic [1:0]              dispMode;
	logic [`CALC_ADDR_W-1:0] dispAddrA;
	logic [`CALC_ADDR_W-1:0] dispAddrB;
	logic [`CALC_DATA_W-1:0] dispDataA;
	logic [`CALC_DATA_W-1:0] dispDataB;

	// expected records in command order
	recordT expQ[$];
	string  nameQ[$];

	// owned by the compare process
	int     errors = 0;
	int     checked = 0;
	int     seen = 0;
	recordT gotRec;
	recordT wantRec;
	string  wantName;

	calcTop uut (
		.clk       (clk),
		.rst       (rst),
		.nibble    (nibble),
		.knobA     (knobA),
		.knobB     (knobB),
		.button    (button),
		.dispReady (dispReady),
		.dispValid (dispValid),
		.dispMode  (dispMode),
		.dispAddrA (dispAddrA),
		.dispAddrB (dispAddrB),
		.dispDataA (dispDataA),
		.dispDataB (dispDataB)
	);

	// 4 ns clock
	initial clk = 1'b0;
	always #2 clk = ~clk;

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// n rising edges and then the drive point just after
	task automatic stepCycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// one detent with the nibble held across the whole turn
	task automatic turnKnob(input logic [3:0] value);
		nibble = value;
		stepCycles(2);
		knobA = 1'b1;
		stepCycles(2);
		knobB = 1'b1;
		stepCycles(4);
		knobA = 1'b0;
		knobB = 1'b0;
		stepCycles(4);
	endtask

	// high address nibble with junk above bit 0
	function automatic logic [3:0] addrHigh(input logic [`CALC_ADDR_W-1:0] a);
		logic [31:0] r;
		r = nextRand();
		return {r[31:29], a[4]};
	endfunction

	function automatic recordT currentRecord();
		return {dispMode, dispAddrA, dispAddrB, dispDataA, dispDataB};
	endfunction

	// whole command in opcode-table order
	task automatic enterCommand(
		input string                   name,
		input logic [2:0]              op,
		input logic [`CALC_ADDR_W-1:0] rdA,
		input logic [`CALC_ADDR_W-1:0] rdB,
		input logic [`CALC_ADDR_W-1:0] wr,
		input logic [3:0]              sh,
		input logic [`CALC_DATA_W-1:0] imm
	);
		logic [3:0] nibs[$];
		nibs.push_back({1'b0, op});
		if (op != 3'd0) begin
			nibs.push_back(rdA[3:0]);
			nibs.push_back(addrHigh(rdA));
		end
		if (op == 3'd2 || op == 3'd4 || op == 3'd5 || op == 3'd6) begin
			nibs.push_back(rdB[3:0]);
			nibs.push_back(addrHigh(rdB));
		end
		if (op == 3'd7) begin
			nibs.push_back(sh);
		end
		if (op != 3'd1 && op != 3'd2) begin
			nibs.push_back(wr[3:0]);
			nibs.push_back(addrHigh(wr));
		end
		// immediate with the low nibble first
		if (op == 3'd0 || op == 3'd3 || op == 3'd4) begin
			nibs.push_back(imm[3:0]);
			nibs.push_back(imm[7:4]);
			nibs.push_back(imm[11:8]);
			nibs.push_back(imm[15:12]);
		end
		// queued before the turns since the record can follow the last detent closely
		expQ.push_back(calcExpected(op, rdA, rdB, wr, sh, imm, modelRegs));
		nameQ.push_back(name);
		foreach (nibs[i]) begin
			turnKnob(nibs[i]);
		end
	endtask

	// until every queued record has been taken
	task automatic waitIdle();
		while (expQ.size() != 0) begin
			stepCycles(1);
		end
		stepCycles(4);
	endtask

	//////////////////////////////
	// compare
	//////////////////////////////

	// negedge sample with the handshake settled for the next rising edge
	always @(negedge clk) begin
		if (!rst && dispValid && dispReady) begin
			gotRec = currentRecord();
			seen++;
			if (expQ.size() == 0) begin
				errors++;
				$display("unexpected display record with nothing queued: %s",
					recordText(gotRec));
			end else begin
				wantRec  = expQ.pop_front();
				wantName = nameQ.pop_front();
				checked++;
				if (gotRec !== wantRec) begin
					errors++;
					$display("error %s: expected %s actual %s",
						wantName, recordText(wantRec), recordText(gotRec));
				end else begin
					$display("ok %s: %s", wantName, recordText(gotRec));
				end
			end
		end
	end

	// watchdog
	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout: no end of run after %0d cycles", watchdogCycles);
		$display("sim failed");
		$finish;
	end

	//////////////////////////////
	// tests
	//////////////////////////////

	initial begin
		int                      k;
		int                      mainErrors;
		int                      seenBefore;
		logic [31:0]             r;
		logic [`CALC_ADDR_W-1:0] a;
		logic [`CALC_ADDR_W-1:0] b;
		logic [`CALC_ADDR_W-1:0] w;
		logic [`CALC_ADDR_W-1:0] used [6];
		recordT                  held;

		mainErrors = 0;
		rst        = 1'b1;
		nibble     = 4'd0;
		knobA      = 1'b0;
		knobB      = 1'b0;
		button     = 1'b0;
		dispReady  = 1'b1;
		stepCycles(4);
		rst = 1'b0;
		stepCycles(4);

		// immediates with alternating address bit 4
		for (k = 0; k < 6; k++) begin
			r       = nextRand();
			used[k] = {k[0], r[3:0]};
			enterCommand($sformatf("imm %0d", k), 3'd0, '0, '0, used[k], 4'd0, r[31:16]);
			waitIdle();
		end
		for (k = 0; k < 6; k++) begin
			enterCommand($sformatf("read back %0d", k), 3'd1, used[k], '0, '0, 4'd0, '0);
			waitIdle();
		end

		// add then subtract on random operands
		for (k = 0; k < 6; k++) begin
			r = nextRand();
			a = used[int'(r[7:0]) % 6];
			b = used[int'(r[15:8]) % 6];
			w = r[20:16];
			enterCommand($sformatf("%s %0d", (k < 3) ? "add" : "sub", k),
				(k < 3) ? 3'd5 : 3'd6, a, b, w, 4'd0, '0);
			waitIdle();
		end
		// source and destination the same register
		enterCommand("add same reg", 3'd5, used[1], used[1], used[1], 4'd0, '0);
		waitIdle();
		enterCommand("sub same reg", 3'd6, used[2], used[2], used[2], 4'd0, '0);
		waitIdle();

		// shifts of a value with both end bits set
		r = nextRand();
		enterCommand("shift source", 3'd0, '0, '0, 5'd17, 4'd0, r[31:16] | 16'h8001);
		waitIdle();
		for (k = 0; k < 16; k++) begin
			r = nextRand();
			w = (r[4:0] == 5'd17) ? 5'd16 : r[4:0];
			enterCommand($sformatf("shift %0d", k), 3'd7, 5'd17, '0, w, k[3:0], '0);
			waitIdle();
		end

		// combined reads and writes
		enterCommand("read ab", 3'd2, used[0], used[3], '0, 4'd0, '0);
		waitIdle();
		r = nextRand();
		enterCommand("read a write", 3'd3, used[1], '0, 5'd26, 4'd0, r[15:0]);
		waitIdle();
		enterCommand("read ab write", 3'd4, used[2], used[5], 5'd9, 4'd0, r[31:16]);
		waitIdle();
		r = nextRand();
		enterCommand("read a write same", 3'd3, used[0], '0, used[0], 4'd0, r[15:0]);
		waitIdle();
		enterCommand("read ab write b", 3'd4, used[3], 5'd21, 5'd21, 4'd0, r[31:16]);
		waitIdle();

		// partial immediate write then abandon
		seenBefore = seen;
		turnKnob(4'd0);
		turnKnob(4'd7);
		turnKnob(4'd1);
		turnKnob(4'd5);
		stepCycles(2);
		button = 1'b1;
		stepCycles(2);
		button = 1'b0;
		// rest of the abandoned entry becomes an unfinished new one
		turnKnob(4'd0);
		turnKnob(4'd3);
		turnKnob(4'd9);
		stepCycles(2);
		button = 1'b1;
		stepCycles(2);
		button = 1'b0;
		stepCycles(40);
		if (seen != seenBefore) begin
			mainErrors++;
			$display("button: a record appeared for an abandoned entry");
		end else begin
			$display("ok button abandon");
		end
		r = nextRand();
		enterCommand("after button", 3'd0, '0, '0, 5'd28, 4'd0, r[15:0]);
		waitIdle();
		enterCommand("after button read", 3'd1, 5'd28, '0, '0, 4'd0, '0);
		waitIdle();

		// back-pressure over two commands
		dispReady = 1'b0;
		r = nextRand();
		enterCommand("stall write", 3'd0, '0, '0, 5'd13, 4'd0, r[15:0]);
		while (!dispValid) begin
			stepCycles(1);
		end
		held = currentRecord();
		stepCycles(20);
		enterCommand("stall read", 3'd4, 5'd13, used[0], 5'd30, 4'd0, r[31:16]);
		stepCycles(40);
		if (!dispValid || currentRecord() !== held) begin
			mainErrors++;
			$display("error stall hold: expected %s actual %s",
				recordText(held), recordText(currentRecord()));
		end else begin
			$display("ok stall hold");
		end
		dispReady = 1'b1;
		waitIdle();

		// room for a stray record
		stepCycles(40);
		$display("%0d records checked, %0d errors", checked, errors + mainErrors);
		if (errors + mainErrors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
